// ==== board_reset_ctrl.f ====
logic/reset_seq_pkg.sv
logic/status_pkg.sv
logic/reset_request_gen.sv
logic/reset_step.sv
logic/status_regs.sv
logic/board_reset_ctrl.sv
dv/tb_clock_gen.sv
dv/tb_peripheral_model.sv
dv/board_reset_ctrl_tb.sv

// ==== dv/board_reset_ctrl_tb.sv ====
`timescale 1ns/100ps

module board_reset_ctrl_tb import reset_seq_pkg::*, status_pkg::*; #(
	parameter int NSTEP = 4,
	parameter timeout_t STARTUP_DELAY = 32'd100,
	parameter len_t READY_LEN = 16'd10,
	parameter len_t RESET_LEN = 16'd10,
	parameter timeout_t TIMEOUT = 32'd200,
	parameter int LINK_STEP = 2
);

	// cycle budgets per test
	localparam int CHAIN_CYCLES = NSTEP * (int'(READY_LEN) + int'(RESET_LEN) + 24);
	localparam int T_POWER_ON = int'(STARTUP_DELAY) + 120 + CHAIN_CYCLES;
	localparam int T_RERUN = CHAIN_CYCLES + 60;
	localparam int T_TIMEOUT = int'(TIMEOUT) + 2 * CHAIN_CYCLES + 100;
	localparam int WATCHDOG_CYCLES = T_POWER_ON + 2 * T_RERUN + T_TIMEOUT + 700;
	localparam logic [NSTEP-1:0] ALL_STEPS = {NSTEP{1'b1}};
	localparam logic [NSTEP-1:0] ONE_STEP = {{(NSTEP-1){1'b0}}, 1'b1};

	logic hw;
	logic poweronreset;
	logic supply_good;
	logic hw_reset_req;
	logic link_los;
	logic [NSTEP-1:0] step_done_in;
	logic cmd_valid;
	status_op_t cmd_op;
	logic [NSTEP-1:0] step_reset;
	logic all_done;
	status_word_t rdata;
	logic rvalid;
	logic [NSTEP-1:0] withhold;

	string test_name = "reset";
	int value_errors = 0;
	int other_errors = 0;
	// expected chain state, kept from the events the stimulus causes
	logic [NSTEP-1:0] exp_done;
	logic [NSTEP-1:0] exp_error;
	int unsigned exp_count;
	start_cause_t exp_cause;
	logic cmd_q = 1'b0;
	status_op_t op_q;
	status_word_t exp_word;
	logic [NSTEP-1:0] mon_reset_q = '0;
	logic all_done_q = 1'b0;
	int width [NSTEP];
	int pulse_cnt [NSTEP];
	int pulse_base [NSTEP];
	int rise_cycle [NSTEP];
	int good_run = 0;  // consecutive cycles with supply_good high
	int cyc = 0;       // cycles since reset release
	int all_done_rises = 0;
	int rises_base = 0;
	step_state_t step1_state;

	tb_clock_gen #(.PERIOD(8.0), .RESET_CYCLES(10)) i_clk (.hw(hw), .poweronreset(poweronreset));

	tb_peripheral_model #(.NSTEP(NSTEP), .SEED(32'd90238)) i_periph (
		.hw(hw),
		.step_reset(step_reset),
		.withhold(withhold),
		.step_done_in(step_done_in)
	);

	board_reset_ctrl #(
		.NSTEP(NSTEP),
		.STARTUP_DELAY(STARTUP_DELAY),
		.READY_LEN(READY_LEN),
		.RESET_LEN(RESET_LEN),
		.TIMEOUT(TIMEOUT),
		.LINK_STEP(LINK_STEP)
	) i_dut (
		.hw(hw),
		.poweronreset(poweronreset),
		.supply_good(supply_good),
		.hw_reset_req(hw_reset_req),
		.link_los(link_los),
		.step_done_in(step_done_in),
		.cmd_valid(cmd_valid),
		.cmd_op(cmd_op),
		.step_reset(step_reset),
		.all_done(all_done),
		.rdata(rdata),
		.rvalid(rvalid)
	);

	// status word as the read commands define it
	function automatic status_word_t predict_status(input status_op_t op,
		input logic [NSTEP-1:0] done_v, input logic [NSTEP-1:0] error_v,
		input int unsigned count, input start_cause_t cause);
		status_word_t word;
		word = '0;
		case (op)
			op_read_done: word[NSTEP-1:0] = done_v;
			op_read_error: word[NSTEP-1:0] = error_v;
			op_read_count: word = status_word_t'(count);
			op_read_cause: word[1:0] = cause;
			default: word = '0;
		endcase
		return word;
	endfunction

	// every answer one cycle after its command
	always @(posedge hw) begin
		if (!poweronreset) begin
			assert (rvalid === cmd_q) else begin
				$display("Fail %s: rvalid expected %b, actual %b",
					test_name, cmd_q, rvalid);
				value_errors++;
			end
			if (cmd_q) begin
				assert (rdata === exp_word) else begin
					$display("Fail %s: %s expected %h, actual %h",
						test_name, op_q.name(), exp_word, rdata);
					value_errors++;
				end
			end
		end
		cmd_q = cmd_valid;
		op_q = cmd_op;
		if (cmd_valid)
			exp_word = predict_status(cmd_op, exp_done, exp_error, exp_count, exp_cause);
	end

	// step reset order, qualification and pulse width
	always @(posedge hw) begin
		if (!poweronreset) begin
			for (int k = 0; k < NSTEP; k++) begin
				if (step_reset[k] && !mon_reset_q[k]) begin
					pulse_cnt[k]++;
					rise_cycle[k] = cyc;
					width[k] = 0;
					if (k == 0) begin
						assert (good_run >= READY_LEN && cyc >= STARTUP_DELAY + READY_LEN)
						else begin
							$display("step 0 reset rose after %0d good supply cycles, cycle %0d",
								good_run, cyc);
							other_errors++;
						end
					end else begin
						assert (step_done_in[k-1]) else begin
							$display("step %0d reset rose while peripheral %0d not done",
								k, k - 1);
							other_errors++;
						end
					end
				end
				if (step_reset[k])
					width[k]++;
				if (!step_reset[k] && mon_reset_q[k]) begin
					assert (width[k] == RESET_LEN) else begin
						$display("Fail %s: step %0d reset width expected %0d, actual %0d",
							test_name, k, RESET_LEN, width[k]);
						value_errors++;
					end
				end
			end
			if (all_done && !all_done_q) begin
				all_done_rises++;
				assert (step_done_in[NSTEP-1] && step_reset == '0) else begin
					$display("all_done rose before the last step completed");
					other_errors++;
				end
			end
			good_run = supply_good ? good_run + 1 : 0;
			cyc++;
			mon_reset_q = step_reset;
			all_done_q = all_done;
		end
	end

	task automatic wait_all_done(input logic level, input int max_cycles);
		int n;
		n = 0;
		while (all_done !== level && n < max_cycles) begin
			@(posedge hw);
			n++;
		end
		assert (all_done === level) else begin
			$display("all_done did not go to %b within %0d cycles in test %s",
				level, max_cycles, test_name);
			other_errors++;
		end
	endtask

	task automatic wait_step_pulse(input int k, input int max_cycles);
		int n;
		n = 0;
		while (step_reset[k] !== 1'b1 && n < max_cycles) begin
			@(posedge hw);
			n++;
		end
		while (step_reset[k] !== 1'b0 && n < max_cycles) begin
			@(posedge hw);
			n++;
		end
		assert (n < max_cycles) else begin
			$display("no reset pulse on step %0d in test %s", k, test_name);
			other_errors++;
		end
	endtask

	task automatic mark_pulse_base();
		@(negedge hw);
		for (int k = 0; k < NSTEP; k++)
			pulse_base[k] = pulse_cnt[k];
		rises_base = all_done_rises;
	endtask

	task automatic check_pulses(input logic [NSTEP-1:0] expect_mask);
		int delta;
		@(negedge hw);
		for (int k = 0; k < NSTEP; k++) begin
			delta = pulse_cnt[k] - pulse_base[k];
			assert (delta == int'(expect_mask[k])) else begin
				$display("Fail %s: step %0d reset pulses expected %0d, actual %0d",
					test_name, k, expect_mask[k], delta);
				value_errors++;
			end
		end
	endtask

	task automatic issue_cmd(input status_op_t op);
		@(posedge hw);
		cmd_valid <= 1'b1;
		cmd_op <= op;
	endtask

	// back to back reads, then one on its own
	task automatic read_all();
		issue_cmd(op_read_done);
		issue_cmd(op_read_error);
		issue_cmd(op_read_count);
		issue_cmd(op_nop);
		@(posedge hw);
		cmd_valid <= 1'b0;
		issue_cmd(op_read_cause);
		@(posedge hw);
		cmd_valid <= 1'b0;
		repeat (3) @(posedge hw);
	endtask

	task automatic request_restart();
		@(posedge hw);
		hw_reset_req <= 1'b1;
		repeat (4) @(posedge hw);
		hw_reset_req <= 1'b0;
	endtask

	task automatic reconnect_link();
		@(posedge hw);
		link_los <= 1'b1;
		repeat (10) @(posedge hw);
		link_los <= 1'b0;  // falling edge means the link is back
	endtask

	initial begin
		supply_good = 1'b0;
		hw_reset_req = 1'b0;
		link_los = 1'b0;
		cmd_valid = 1'b0;
		cmd_op = op_nop;
		withhold = '0;
		exp_done = '0;
		exp_error = '0;
		exp_count = 0;
		exp_cause = cause_none;

		test_name = "power_on";
		wait (!poweronreset);
		repeat (20) @(posedge hw);
		supply_good <= 1'b1;
		repeat (85) @(posedge hw);
		supply_good <= 1'b0;  // dip while step 0 qualifies
		@(posedge hw);
		supply_good <= 1'b1;
		wait_all_done(1'b1, T_POWER_ON);
		check_pulses(ALL_STEPS);
		exp_done = ALL_STEPS;
		exp_count = 1;
		exp_cause = cause_poweron;

		test_name = "status_read";
		read_all();

		test_name = "hw_request";
		mark_pulse_base();
		request_restart();
		wait_all_done(1'b0, 20);
		wait_all_done(1'b1, T_RERUN);
		check_pulses(ALL_STEPS);
		for (int k = 1; k < NSTEP; k++) begin
			assert (rise_cycle[k] > rise_cycle[k-1]) else begin
				$display("step %0d reset rose before step %0d", k, k - 1);
				other_errors++;
			end
		end
		exp_count = 2;
		exp_cause = cause_hw_request;
		read_all();

		test_name = "link_reconnect";
		mark_pulse_base();
		reconnect_link();
		wait_all_done(1'b0, 20);
		wait_all_done(1'b1, T_RERUN);
		repeat (20) @(posedge hw);  // long enough for a wrongly chained step 3
		check_pulses(ONE_STEP << LINK_STEP);
		exp_count = 3;
		exp_cause = cause_link;
		read_all();

		test_name = "timeout";
		mark_pulse_base();
		@(posedge hw);
		withhold <= ONE_STEP << 1;
		request_restart();
		wait_step_pulse(1, T_RERUN);
		exp_done = ONE_STEP;
		exp_cause = cause_hw_request;
		repeat (int'(TIMEOUT) - 8) @(posedge hw);
		issue_cmd(op_read_error);  // step 1 still inside its timeout
		@(posedge hw);
		cmd_valid <= 1'b0;
		repeat (12) @(posedge hw);
		check_pulses(ONE_STEP | (ONE_STEP << 1));
		assert (all_done_rises == rises_base && all_done === 1'b0) else begin
			$display("all_done rose although step 1 timed out");
			other_errors++;
		end
		step1_state = i_dut.gen_step[1].i_step.state;
		assert (step1_state == st_error) else begin
			$display("step 1 is in %s and not in st_error after the timeout",
				step1_state.name());
			other_errors++;
		end
		exp_error = ONE_STEP << 1;
		read_all();
		@(posedge hw);
		withhold <= '0;
		request_restart();
		wait_all_done(1'b1, T_RERUN);
		exp_done = ALL_STEPS;
		exp_error = '0;
		exp_count = 4;
		read_all();

		$display("errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge hw);
		$display("watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
		$display("errors: %0d value, %0d other", value_errors, other_errors + 1);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter real PERIOD = 8.0,
	parameter int RESET_CYCLES = 10
) (
	output logic hw,
	output logic poweronreset
);

	initial begin
		hw = 1'b0;
		forever #(PERIOD / 2.0) hw = ~hw;
	end

	// released on a rising edge like any other synchronous input
	initial begin
		poweronreset = 1'b1;
		repeat (RESET_CYCLES) @(posedge hw);
		poweronreset <= 1'b0;
	end

endmodule

// ==== dv/tb_peripheral_model.sv ====
`timescale 1ns/100ps

module tb_peripheral_model #(
	parameter int NSTEP = 4,
	parameter logic [31:0] SEED = 32'd90238
) (
	input  logic hw,
	input  logic [NSTEP-1:0] step_reset,
	input  logic [NSTEP-1:0] withhold,  // these peripherals never report done
	output logic [NSTEP-1:0] step_done_in
);

	logic [31:0] lfsr;
	logic [NSTEP-1:0] reset_q;
	logic [3:0] delay_bits;
	int wait_cnt [NSTEP];  // cycles left until done rises

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		else
			return s >> 1;
	endfunction

	initial begin
		lfsr = SEED;
		reset_q = '0;
		step_done_in = '1;  // peripherals come up claiming done
		for (int k = 0; k < NSTEP; k++)
			wait_cnt[k] = 0;
	end

	always @(posedge hw) begin
		for (int k = 0; k < NSTEP; k++) begin
			if (step_reset[k] && !reset_q[k]) begin
				step_done_in[k] <= 1'b0;
				wait_cnt[k] = 0;
			end else if (!step_reset[k] && reset_q[k]) begin
				for (int b = 0; b < 4; b++) begin
					delay_bits = {delay_bits[2:0], lfsr[0]};
					lfsr = lfsr_next(lfsr);  // one step per bit taken
				end
				wait_cnt[k] = int'(delay_bits);
				if (wait_cnt[k] == 0 && !withhold[k])
					step_done_in[k] <= 1'b1;
			end else if (wait_cnt[k] > 0) begin
				wait_cnt[k] = wait_cnt[k] - 1;
				if (wait_cnt[k] == 0 && !withhold[k])
					step_done_in[k] <= 1'b1;
			end
		end
		reset_q = step_reset;
	end

endmodule

// ==== logic/board_reset_ctrl.sv ====
`timescale 1ns/100ps

module board_reset_ctrl import reset_seq_pkg::*, status_pkg::*; #(
	parameter int NSTEP = 4,
	parameter timeout_t STARTUP_DELAY = 32'd100,
	parameter len_t READY_LEN = 16'd10,
	parameter len_t RESET_LEN = 16'd10,
	parameter timeout_t TIMEOUT = 32'd0,
	parameter int LINK_STEP = 2
) (
	input  logic hw,
	input  logic poweronreset,
	input  logic supply_good,
	input  logic hw_reset_req,
	input  logic link_los,
	input  logic [NSTEP-1:0] step_done_in,
	input  logic cmd_valid,
	input  status_op_t cmd_op,
	output logic [NSTEP-1:0] step_reset,
	output logic all_done,
	output status_word_t rdata,
	output logic rvalid
);

	logic chain_start;
	logic link_restart;
	logic [NSTEP-1:0] step_go;
	logic [NSTEP-1:0] step_ready;
	logic [NSTEP-1:0] step_restart;
	logic [NSTEP-1:0] done;
	logic [NSTEP-1:0] error;
	logic [NSTEP-1:0] step_strobe;

	reset_request_gen #(
		.STARTUP_DELAY(STARTUP_DELAY)
	) i_request (
		.hw(hw),
		.poweronreset(poweronreset),
		.hw_reset_req(hw_reset_req),
		.link_los(link_los),
		.chain_start(chain_start),
		.link_restart(link_restart)
	);

	// step 0 starts on the chain start, every later one on its predecessor
	assign step_go = {step_strobe[NSTEP-2:0], chain_start};

	// a stale peripheral done is not trusted until its own step has finished
	assign step_ready = {step_done_in[NSTEP-2:0] & done[NSTEP-2:0], supply_good};

	genvar k;
	generate
		for (k = 0; k < NSTEP; k = k + 1) begin : gen_step
			assign step_restart[k] = chain_start | (link_restart & (k == LINK_STEP));

			reset_step #(
				.READY_LEN(READY_LEN),
				.RESET_LEN(RESET_LEN),
				.TIMEOUT(TIMEOUT)
			) i_step (
				.hw(hw),
				.poweronreset(poweronreset),
				.restart(step_restart[k]),
				.go(step_go[k]),
				.ready_in(step_ready[k]),
				.done_in(step_done_in[k]),
				.step_reset(step_reset[k]),
				.done(done[k]),
				.error(error[k]),
				.step_strobe(step_strobe[k])
			);
		end
	endgenerate

	status_regs #(
		.NSTEP(NSTEP)
	) i_status (
		.hw(hw),
		.poweronreset(poweronreset),
		.chain_start(chain_start),
		.link_restart(link_restart),
		.done(done),
		.error(error),
		.cmd_valid(cmd_valid),
		.cmd_op(cmd_op),
		.rdata(rdata),
		.rvalid(rvalid),
		.all_done(all_done)
	);

endmodule

// ==== logic/reset_request_gen.sv ====
`timescale 1ns/100ps

module reset_request_gen import reset_seq_pkg::*; #(
	parameter timeout_t STARTUP_DELAY = 32'd100
) (
	input  logic hw,
	input  logic poweronreset,
	input  logic hw_reset_req,
	input  logic link_los,
	output logic chain_start,
	output logic link_restart
);

	// last count value before the start-up pulse
	localparam timeout_t STARTUP_LAST = (STARTUP_DELAY > 0) ? STARTUP_DELAY - 32'd1 : '0;

	timeout_t startup_cnt;
	logic startup_fired;  // start-up pulse only once per power-on
	logic startup_hit;

	// [0] and [1] are the synchronizer, [2] keeps the previous value
	logic [2:0] req_sync;
	logic [2:0] los_sync;
	logic req_rise;
	logic los_fall;

	assign startup_hit = ~startup_fired && (startup_cnt == STARTUP_LAST);
	assign req_rise = req_sync[1] & ~req_sync[2];
	assign los_fall = ~los_sync[1] & los_sync[2];  // optical link came back

	always_ff @(posedge hw) begin
		if (poweronreset) begin
			startup_cnt <= '0;
			startup_fired <= 1'b0;
		end else begin
			if (!startup_fired)
				startup_cnt <= startup_cnt + 32'd1;
			if (startup_hit)
				startup_fired <= 1'b1;
		end
	end

	always_ff @(posedge hw) begin
		if (poweronreset) begin
			req_sync <= '0;
			los_sync <= '0;
		end else begin
			req_sync <= {req_sync[1:0], hw_reset_req};
			los_sync <= {los_sync[1:0], link_los};
		end
	end

	// registered strobes, one cycle each
	always_ff @(posedge hw) begin
		if (poweronreset) begin
			chain_start <= 1'b0;
			link_restart <= 1'b0;
		end else begin
			chain_start <= startup_hit | req_rise;  // power-on and request share one start
			link_restart <= los_fall;
		end
	end

endmodule

// ==== logic/reset_seq_pkg.sv ====
package reset_seq_pkg;

	// cycle count for ready qualification and reset pulse length
	typedef logic [15:0] len_t;

	// cycle count for the done timeout and the start-up delay
	// zero as a timeout value means wait forever
	typedef logic [31:0] timeout_t;

	// state of one sequencing step
	typedef enum logic [2:0] {
		st_idle,        // after power-on, until the chain starts
		st_wait_ready,  // qualifying the readiness input
		st_reset,       // peripheral reset asserted
		st_wait_done,   // waiting for the peripheral done
		st_done,
		st_error        // done never came within the timeout
	} step_state_t;

endpackage

// ==== logic/reset_step.sv ====
`timescale 1ns/100ps

module reset_step import reset_seq_pkg::*; #(
	parameter len_t READY_LEN = 16'd10,
	parameter len_t RESET_LEN = 16'd10,
	parameter timeout_t TIMEOUT = 32'd0
) (
	input  logic hw,
	input  logic poweronreset,
	input  logic restart,
	input  logic go,
	input  logic ready_in,
	input  logic done_in,
	output logic step_reset,
	output logic done,
	output logic error,
	output logic step_strobe
);

	// terminal counts, a length of zero behaves like one
	localparam timeout_t READY_LAST = (READY_LEN > 0) ? timeout_t'(READY_LEN) - 32'd1 : '0;
	localparam timeout_t RESET_LAST = (RESET_LEN > 0) ? timeout_t'(RESET_LEN) - 32'd1 : '0;
	localparam timeout_t TIMEOUT_LAST = (TIMEOUT > 0) ? TIMEOUT - 32'd1 : '0;

	step_state_t state;
	timeout_t cnt;   // shared by ready, reset and timeout phases
	logic chained;   // run released by the previous step, so pass it on

	always_ff @(posedge hw) begin
		if (poweronreset) begin
			state <= st_idle;
			cnt <= '0;
			chained <= 1'b0;
			step_reset <= 1'b0;
			done <= 1'b0;
			error <= 1'b0;
			step_strobe <= 1'b0;
		end else begin
			step_strobe <= 1'b0;
			if (restart || go) begin
				// a rerun on its own does not start the steps behind it
				state <= st_wait_ready;
				cnt <= '0;
				chained <= go;
				step_reset <= 1'b0;
				done <= 1'b0;
				error <= 1'b0;
			end else begin
				case (state)
					st_wait_ready: begin
						if (!ready_in) begin
							cnt <= '0;  // any low cycle starts the count over
						end else if (cnt == READY_LAST) begin
							state <= st_reset;
							cnt <= '0;
							step_reset <= 1'b1;
						end else begin
							cnt <= cnt + 32'd1;
						end
					end
					st_reset: begin
						if (cnt == RESET_LAST) begin
							state <= st_wait_done;
							cnt <= '0;
							step_reset <= 1'b0;
						end else begin
							cnt <= cnt + 32'd1;
						end
					end
					st_wait_done: begin
						if (done_in) begin
							state <= st_done;
							done <= 1'b1;
							step_strobe <= chained;
						end else if (TIMEOUT != 0) begin
							if (cnt == TIMEOUT_LAST) begin
								state <= st_error;
								error <= 1'b1;
							end else begin
								cnt <= cnt + 32'd1;
							end
						end
					end
					default: begin
						// idle, done and error hold until the next start
						state <= state;
					end
				endcase
			end
		end
	end

endmodule

// ==== logic/status_pkg.sv ====
package status_pkg;

	// read data word returned for every command
	typedef logic [31:0] status_word_t;

	// read command opcodes
	typedef enum logic [2:0] {
		op_nop        = 3'd0,
		op_read_done  = 3'd1,  // done vector, one bit per step
		op_read_error = 3'd2,  // error vector, one bit per step
		op_read_count = 3'd3,  // completed sequences
		op_read_cause = 3'd4   // cause of the last start
	} status_op_t;

	// what started the last sequence
	typedef enum logic [1:0] {
		cause_none       = 2'd0,
		cause_poweron    = 2'd1,
		cause_hw_request = 2'd2,
		cause_link       = 2'd3
	} start_cause_t;

endpackage

// ==== logic/status_regs.sv ====
`timescale 1ns/100ps

module status_regs import status_pkg::*; #(
	parameter int NSTEP = 4
) (
	input  logic hw,
	input  logic poweronreset,
	input  logic chain_start,
	input  logic link_restart,
	input  logic [NSTEP-1:0] done,
	input  logic [NSTEP-1:0] error,
	input  logic cmd_valid,
	input  status_op_t cmd_op,
	output status_word_t rdata,
	output logic rvalid,
	output logic all_done
);

	start_cause_t last_cause;
	logic started;            // a chain start was seen since power-on
	status_word_t seq_count;  // rising edges of all_done
	logic all_set;
	status_word_t answer;

	assign all_set = &done;

	// read mux, zero extended to the word
	always_comb begin
		case (cmd_op)
			op_read_done: answer = status_word_t'(done);
			op_read_error: answer = status_word_t'(error);
			op_read_count: answer = seq_count;
			op_read_cause: answer = status_word_t'(last_cause);
			default: answer = '0;  // op_nop and unused codes
		endcase
	end

	always_ff @(posedge hw) begin
		if (poweronreset) begin
			last_cause <= cause_none;
			started <= 1'b0;
		end else begin
			if (chain_start) begin
				last_cause <= started ? cause_hw_request : cause_poweron;
				started <= 1'b1;
			end else if (link_restart) begin
				last_cause <= cause_link;
			end
		end
	end

	always_ff @(posedge hw) begin
		if (poweronreset) begin
			all_done <= 1'b0;
			seq_count <= '0;
		end else begin
			all_done <= all_set;
			if (all_set && !all_done)
				seq_count <= seq_count + 32'd1;  // counts with the all_done edge
		end
	end

	// answer exactly one cycle after the command
	always_ff @(posedge hw) begin
		if (poweronreset)
			rvalid <= 1'b0;
		else
			rvalid <= cmd_valid;
	end

	always_ff @(posedge hw) begin
		if (cmd_valid)
			rdata <= answer;
	end

endmodule
